// ==== include/marlann_config.svh ====
////////////////////////////////////////////////////////////
// Build-time sizes and latencies of the compute engine.
// Included by the package and by every RTL unit that needs
// a width, a depth or a pipeline distance.
////////////////////////////////////////////////////////////
`ifndef MARLANN_CONFIG_SVH
`define MARLANN_CONFIG_SVH

// external memory data word.
`define MARLANN_MEM_WIDTH 64
// word address on the memory port.
`define MARLANN_MEM_ADDR_WIDTH 16
// byte address and base pointers.
`define MARLANN_BYTE_ADDR_WIDTH 17
// coefficient entries, two memory words each.
`define MARLANN_COEFF_DEPTH 512
`define MARLANN_MEM_LATENCY 3
`define MARLANN_MUL_STAGES 3
// memory slots ahead of stage 1.
`define MARLANN_LOCK_SLOTS 10
`define MARLANN_ACC_WIDTH 32

`endif

// ==== logic/marlann_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the compute engine: the opcode set and
// the layout of the 32-bit instruction word. Units refer
// to them by scoped name.
////////////////////////////////////////////////////////////
`default_nettype none
`include "marlann_config.svh"

package marlann_pkg;

	typedef enum logic [5:0] {
		op_load_coeff0 = 6'd5,
		op_load_coeff1 = 6'd6,
		op_set_vbp     = 6'd8,
		op_add_vbp     = 6'd9,
		op_set_sbp     = 6'd12,
		op_add_sbp     = 6'd13,
		op_set_cbp     = 6'd14,
		op_add_cbp     = 6'd15,
		op_store       = 6'd16,
		op_store0      = 6'd17,
		op_store1      = 6'd18,
		op_ld_set      = 6'd28,
		op_ld_set0     = 6'd29,
		op_ld_set1     = 6'd30,
		op_macc        = 6'd40,
		op_maccz       = 6'd42
	} opcode_t;

	typedef struct packed {
		logic [`MARLANN_BYTE_ADDR_WIDTH-1:0] maddr; // byte address.
		logic [$clog2(`MARLANN_COEFF_DEPTH)-1:0] caddr; // coeff index or shift.
		opcode_t opcode;
	} insn_t;

endpackage

`default_nettype wire

// ==== logic/issue_interlock.sv ====
////////////////////////////////////////////////////////////
// Command acceptance and memory slot interlock. Registers
// the command into stages 1 and 2, keeps VBP and issues
// the vector read for LoadCoeff and MACC in stage 2.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module issue_interlock (
	input  logic clock,
	input  logic reset,
	input  logic cmd_valid,
	input  marlann_pkg::insn_t cmd_insn,
	output logic cmd_ready,
	output logic s1_valid,
	output logic s2_valid,
	output marlann_pkg::insn_t s2_insn,
	output logic rd0_en,
	output logic [`MARLANN_MEM_ADDR_WIDTH-1:0] rd0_addr,
	output logic tick_simd
);
	localparam int slots = `MARLANN_LOCK_SLOTS;
	localparam int ld_slot = 4; // load read in stage 6.

	marlann_pkg::insn_t s1_insn;
	logic [slots-1:0] lock_res, lock_mask;
	logic stall;
	logic [`MARLANN_BYTE_ADDR_WIDTH-1:0] vbp, vec_addr;

	//////////////////////////////////////////////////////////////
	// slot reservation
	always_comb begin
		lock_mask = '0;
		case (s1_insn.opcode)
			marlann_pkg::op_load_coeff0, marlann_pkg::op_load_coeff1,
			marlann_pkg::op_macc, marlann_pkg::op_maccz: lock_mask[0] = 1'b1;
			marlann_pkg::op_ld_set, marlann_pkg::op_ld_set0,
			marlann_pkg::op_ld_set1: lock_mask[ld_slot] = 1'b1;
			marlann_pkg::op_store, marlann_pkg::op_store0,
			marlann_pkg::op_store1: lock_mask[slots-1] = 1'b1; // write at t+11.
			default: ;
		endcase
		if (!s1_valid)
			lock_mask = '0;
	end

	assign stall = |(lock_res & lock_mask);
	assign cmd_ready = !stall;
	assign vec_addr = s1_insn.maddr + vbp;

	//////////////////////////////////////////////////////////////
	// stages 1 and 2
	always_ff @(posedge clock) begin
		lock_res <= (lock_res | (lock_mask & {slots{!stall}})) >> 1;
		if (!stall) begin
			s1_valid <= cmd_valid;
			s1_insn <= cmd_insn;
		end

		s2_valid <= s1_valid && !stall;
		s2_insn <= s1_insn;
		rd0_en <= 1'b0;
		tick_simd <= 1'b0;
		if (s1_valid && !stall) begin
			case (s1_insn.opcode)
				marlann_pkg::op_load_coeff0, marlann_pkg::op_load_coeff1: begin
					rd0_en <= 1'b1;
					rd0_addr <= s1_insn.maddr[`MARLANN_BYTE_ADDR_WIDTH-1:1];
				end
				marlann_pkg::op_set_vbp, marlann_pkg::op_add_vbp:
					vbp <= s1_insn.maddr +
						(s1_insn.opcode == marlann_pkg::op_add_vbp ? vbp : '0);
				marlann_pkg::op_macc, marlann_pkg::op_maccz: begin
					rd0_en <= 1'b1;
					rd0_addr <= vec_addr[`MARLANN_BYTE_ADDR_WIDTH-1:1];
					tick_simd <= 1'b1;
				end
				default: ; // no memory use.
			endcase
		end

		if (reset) begin
			lock_res <= '0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			rd0_en <= 1'b0;
			tick_simd <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/coeff_store.sv ====
////////////////////////////////////////////////////////////
// Coefficient memory with its base pointer CBP. Carries the
// instruction through stages 3 to 5, reads caddr+CBP for
// stage 5 and stores loaded halves from mem_rdata.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module coeff_store (
	input  logic clock,
	input  logic reset,
	input  logic s2_valid,
	input  marlann_pkg::insn_t s2_insn,
	input  logic [`MARLANN_MEM_WIDTH-1:0] mem_rdata,
	output logic s5_valid,
	output marlann_pkg::insn_t s5_insn,
	output logic [2*`MARLANN_MEM_WIDTH-1:0] coeff
);
	localparam int delay = `MARLANN_MEM_LATENCY; // stage 2 read to stage 5 data.
	localparam int s4 = delay - 2;
	localparam int w = `MARLANN_MEM_WIDTH;

	logic [2*w-1:0] coeff_mem [0:`MARLANN_COEFF_DEPTH-1];
	logic [delay-1:0] valid_q;
	marlann_pkg::insn_t insn_q [delay];
	logic [$clog2(`MARLANN_COEFF_DEPTH)-1:0] cbp;

	always_ff @(posedge clock) begin
		valid_q <= {valid_q[delay-2:0], s2_valid};
		insn_q[0] <= s2_insn;
		for (int i = 1; i < delay; i++)
			insn_q[i] <= insn_q[i - 1];

		coeff <= coeff_mem[insn_q[s4].caddr + cbp]; // old CBP for this read.
		if (valid_q[s4] && (insn_q[s4].opcode == marlann_pkg::op_set_cbp ||
				insn_q[s4].opcode == marlann_pkg::op_add_cbp))
			cbp <= insn_q[s4].caddr +
				(insn_q[s4].opcode == marlann_pkg::op_add_cbp ? cbp : '0);

		if (s5_valid && s5_insn.opcode == marlann_pkg::op_load_coeff0)
			coeff_mem[s5_insn.caddr][w-1:0] <= mem_rdata;
		if (s5_valid && s5_insn.opcode == marlann_pkg::op_load_coeff1)
			coeff_mem[s5_insn.caddr][2*w-1:w] <= mem_rdata;

		if (reset)
			valid_q <= '0;
	end

	assign s5_valid = valid_q[delay-1];
	assign s5_insn = insn_q[delay-1];

endmodule

`default_nettype wire

// ==== logic/mul_array.sv ====
////////////////////////////////////////////////////////////
// Sixteen signed 8x8 multipliers. Lane i takes byte (i mod 8)
// of the vector word and byte i of the coefficient entry;
// products leave after a fixed register pipeline.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module mul_array (
	input  logic clock,
	input  logic [`MARLANN_MEM_WIDTH-1:0] a,
	input  logic [2*`MARLANN_MEM_WIDTH-1:0] coeff,
	output logic [15:0][15:0] prod
);
	localparam int stages = `MARLANN_MUL_STAGES;
	localparam int lanes = 2 * `MARLANN_MEM_WIDTH / 8;
	localparam int vec_bytes = `MARLANN_MEM_WIDTH / 8;

	logic [lanes-1:0][15:0] pipe [stages];

	always_ff @(posedge clock) begin
		for (int i = 0; i < lanes; i++)
			pipe[0][i] <= $signed(a[(i % vec_bytes)*8 +: 8]) * $signed(coeff[i*8 +: 8]);
		for (int s = 1; s < stages; s++)
			pipe[s] <= pipe[s - 1];
	end

	assign prod = pipe[stages-1]; // valid in stage 8.

endmodule

`default_nettype wire

// ==== logic/accumulator_unit.sv ====
////////////////////////////////////////////////////////////
// Accumulator datapath, stages 6 to 10. Issues the LdSet
// read, sums the products into acc0 and acc1 in stage 9 and
// produces the shifted, saturated bytes for Store.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module accumulator_unit (
	input  logic clock,
	input  logic reset,
	input  logic s5_valid,
	input  marlann_pkg::insn_t s5_insn,
	input  logic [`MARLANN_MEM_WIDTH-1:0] mem_rdata,
	input  logic [15:0][15:0] prod,
	output logic rd1_en,
	output logic [`MARLANN_MEM_ADDR_WIDTH-1:0] rd1_addr,
	output logic s10_valid,
	output marlann_pkg::insn_t s10_insn,
	output logic [7:0] sat0,
	output logic [7:0] sat1
);
	localparam int s9 = `MARLANN_MEM_LATENCY; // index 0 is stage 6.
	localparam int s10 = s9 + 1;
	localparam int acc_w = `MARLANN_ACC_WIDTH;

	logic [s10:0] valid_q;
	marlann_pkg::insn_t insn_q [s10+1];
	logic signed [acc_w-1:0] sum0_c, sum1_c, sum0, sum1;
	logic signed [acc_w-1:0] acc0, acc1, base0, base1;
	marlann_pkg::opcode_t op9;

	function automatic logic [7:0] saturate(input logic signed [acc_w-1:0] v);
		if (&v[acc_w-1:7] == |v[acc_w-1:7])
			return v[7:0];
		return v[acc_w-1] ? 8'h80 : 8'h7f;
	endfunction

	always_comb begin
		sum0_c = '0;
		sum1_c = '0;
		for (int i = 0; i < 8; i++) begin
			sum0_c = sum0_c + $signed(prod[i]);
			sum1_c = sum1_c + $signed(prod[i + 8]);
		end
	end

	assign op9 = insn_q[s9].opcode;
	assign base0 = (op9 == marlann_pkg::op_maccz) ? '0 : acc0;
	assign base1 = (op9 == marlann_pkg::op_maccz) ? '0 : acc1;

	always_ff @(posedge clock) begin
		valid_q <= {valid_q[s10-1:0], s5_valid};
		insn_q[0] <= s5_insn;
		for (int i = 1; i <= s10; i++)
			insn_q[i] <= insn_q[i - 1];
		sum0 <= sum0_c; // products of stage 8.
		sum1 <= sum1_c;
		sat0 <= saturate(acc0 >>> insn_q[s10].caddr);
		sat1 <= saturate(acc1 >>> insn_q[s10].caddr);

		rd1_en <= s5_valid && (s5_insn.opcode inside {marlann_pkg::op_ld_set,
			marlann_pkg::op_ld_set0, marlann_pkg::op_ld_set1});
		rd1_addr <= s5_insn.maddr[`MARLANN_BYTE_ADDR_WIDTH-1:1];

		if (valid_q[s9]) begin
			if (op9 == marlann_pkg::op_macc || op9 == marlann_pkg::op_maccz) begin
				acc0 <= base0 + sum0;
				acc1 <= base1 + sum1;
			end
			if (op9 == marlann_pkg::op_ld_set || op9 == marlann_pkg::op_ld_set0)
				acc0 <= mem_rdata[acc_w-1:0]; // load data lands now.
			if (op9 == marlann_pkg::op_ld_set || op9 == marlann_pkg::op_ld_set1)
				acc1 <= mem_rdata[2*acc_w-1:acc_w];
		end

		if (reset) begin
			valid_q <= '0;
			rd1_en <= 1'b0;
		end
	end

	assign s10_valid = valid_q[s10];
	assign s10_insn = insn_q[s10];

endmodule

`default_nettype wire

// ==== logic/store_unit.sv ====
////////////////////////////////////////////////////////////
// Store write-back. Keeps SBP, registers the byte mask and
// byte address at the end of stage 10 and drives the write
// in the next cycle, aligned to the even or odd byte lane.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module store_unit (
	input  logic clock,
	input  logic reset,
	input  logic s10_valid,
	input  marlann_pkg::insn_t s10_insn,
	input  logic [7:0] sat0,
	input  logic [7:0] sat1,
	output logic [7:0] wr_en,
	output logic [15:0] wr_addr,
	output logic [63:0] wr_data
);
	localparam int aw = `MARLANN_BYTE_ADDR_WIDTH;

	logic [aw-1:0] sbp, pre_addr;
	logic [1:0] pre_en;

	always_ff @(posedge clock) begin
		pre_en <= 2'b00;
		pre_addr <= s10_insn.maddr + sbp;
		if (s10_valid) begin
			case (s10_insn.opcode)
				marlann_pkg::op_store: pre_en <= 2'b11;
				marlann_pkg::op_store0: pre_en <= 2'b01; // sat0 lane only.
				marlann_pkg::op_store1: pre_en <= 2'b10;
				marlann_pkg::op_set_sbp, marlann_pkg::op_add_sbp:
					sbp <= s10_insn.maddr +
						(s10_insn.opcode == marlann_pkg::op_add_sbp ? sbp : '0);
				default: ;
			endcase
		end
		if (reset)
			pre_en <= 2'b00;
	end

	// sat bytes arrive one cycle after the store left stage 10.
	always_comb begin
		wr_en = {6'b0, pre_en} << pre_addr[0];
		wr_data = {48'b0, sat1, sat0} << (8 * pre_addr[0]);
		wr_addr = pre_addr[aw-1:1];
	end

endmodule

`default_nettype wire

// ==== logic/marlann_compute.sv ====
////////////////////////////////////////////////////////////
// Top of the compute engine. Takes one instruction per
// accepted command and shares a single memory port between
// the vector read, the load read and the store write.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "marlann_config.svh"

module marlann_compute (
	input  logic clock,
	input  logic reset,
	input  logic cmd_valid,
	input  marlann_pkg::insn_t cmd_insn,
	input  logic [`MARLANN_MEM_WIDTH-1:0] mem_rdata,
	output logic busy,
	output logic cmd_ready,
	output logic mem_ren,
	output logic tick_simd,
	output logic tick_nosimd,
	output logic [`MARLANN_MEM_WIDTH/8-1:0] mem_wen,
	output logic [`MARLANN_MEM_ADDR_WIDTH-1:0] mem_addr,
	output logic [`MARLANN_MEM_WIDTH-1:0] mem_wdata
);
	localparam int drain_w = $clog2(`MARLANN_LOCK_SLOTS);
	localparam int drain_len = `MARLANN_LOCK_SLOTS - 1;

	logic s1_valid, s2_valid, s5_valid, s10_valid;
	marlann_pkg::insn_t s2_insn, s5_insn, s10_insn;
	logic rd0_en, rd1_en;
	logic [`MARLANN_MEM_ADDR_WIDTH-1:0] rd0_addr, rd1_addr, wr_addr;
	logic [`MARLANN_MEM_WIDTH/8-1:0] wr_en;
	logic [`MARLANN_MEM_WIDTH-1:0] wr_data;
	logic [2*`MARLANN_MEM_WIDTH-1:0] coeff;
	logic [15:0][15:0] prod;
	logic [7:0] sat0, sat1;
	logic [drain_w-1:0] drain;

	issue_interlock u_issue (.clock, .reset, .cmd_valid, .cmd_insn, .cmd_ready, .s1_valid,
		.s2_valid, .s2_insn, .rd0_en, .rd0_addr, .tick_simd);
	coeff_store u_coeff (.clock, .reset, .s2_valid, .s2_insn, .mem_rdata, .s5_valid,
		.s5_insn, .coeff);
	mul_array u_mul (.clock, .a(mem_rdata), .coeff, .prod);
	accumulator_unit u_acc (.clock, .reset, .s5_valid, .s5_insn, .mem_rdata, .prod,
		.rd1_en, .rd1_addr, .s10_valid, .s10_insn, .sat0, .sat1);
	store_unit u_store (.clock, .reset, .s10_valid, .s10_insn, .sat0, .sat1, .wr_en,
		.wr_addr, .wr_data);

	// the slot window keeps these one-hot.
	assign mem_ren = rd0_en | rd1_en;
	assign mem_wen = wr_en;
	assign mem_addr = ({`MARLANN_MEM_ADDR_WIDTH{rd0_en}} & rd0_addr) |
		({`MARLANN_MEM_ADDR_WIDTH{rd1_en}} & rd1_addr) |
		({`MARLANN_MEM_ADDR_WIDTH{|wr_en}} & wr_addr);
	assign mem_wdata = wr_data;
	assign tick_nosimd = s2_valid && !tick_simd;

	// stages 3 to 11 are covered by a countdown from stage 2.
	always_ff @(posedge clock) begin
		if (reset)
			drain <= '0;
		else if (s2_valid)
			drain <= drain_w'(drain_len);
		else if (drain != '0)
			drain <= drain - 1'b1;
	end

	assign busy = s1_valid | s2_valid | s5_valid | s10_valid | (drain != '0);

	port_exclusive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({rd0_en, rd1_en, |wr_en}))
		else $error("memory port driven by more than one unit");

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
////////////////////////////////////////////////////////////
// Free-running clock for the testbench, 40 ns period.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter real period = 40.0
) (
	output logic clock
);
	initial clock = 1'b0;

	always #(period / 2.0) clock = ~clock; // half period per phase.

endmodule

`default_nettype wire

// ==== verification/marlann_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench of the compute engine. Runs command programs
// through the DUT against a 3-cycle memory model, predicts
// every write with an in-order reference model and checks
// port use, ticks and drain with assertions.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module marlann_tb;
	logic clock, reset, cmd_valid, busy, cmd_ready, mem_ren, tick_simd, tick_nosimd;
	marlann_pkg::insn_t cmd_insn;
	logic [63:0] mem_rdata, mem_wdata;
	logic [7:0] mem_wen;
	logic [15:0] mem_addr;

	logic [63:0] mem [0:65535];
	logic [127:0] coeff_ref [0:511];
	logic [2:0] rd_valid;
	logic [15:0] rd_addr [3];
	logic signed [31:0] acc0, acc1;
	logic [16:0] vbp, sbp;
	logic [8:0] cbp;
	logic [15:0] exp_addr [$];
	logic [7:0] exp_mask [$];
	logic [63:0] exp_data [$];
	marlann_pkg::insn_t prog [$];
	int simd_exp, nosimd_exp, simd_seen, nosimd_seen, stores, writes, stalls;

	tb_clock u_clock (.clock);

	marlann_compute DUT (.clock, .reset, .cmd_valid, .cmd_insn, .mem_rdata, .busy,
		.cmd_ready, .mem_ren, .tick_simd, .tick_nosimd, .mem_wen, .mem_addr, .mem_wdata);

	task automatic abort(input string why);
		if (why != "")
			$display("%0t: %s", $time, why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [63:0] got, exp);
		$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		abort("");
	endtask

	function automatic marlann_pkg::insn_t make(marlann_pkg::opcode_t op, int maddr, int caddr);
		marlann_pkg::insn_t i;
		i.opcode = op;
		i.maddr = maddr[16:0];
		i.caddr = caddr[8:0];
		return i;
	endfunction

	function automatic logic [7:0] clamp_byte(input logic signed [31:0] v);
		if (v > 127)
			return 8'h7f;
		if (v < -128)
			return 8'h80;
		return v[7:0];
	endfunction

	//////////////////////////////////////////////////////////////
	// reference model, one accepted command at a time
	task automatic model(input marlann_pkg::insn_t c);
		logic [16:0] b;
		logic [63:0] v;
		logic [127:0] e;
		logic signed [31:0] s0, s1;
		logic [1:0] lanes;
		s0 = 0;
		s1 = 0;
		lanes = 2'b00;
		case (c.opcode)
			marlann_pkg::op_load_coeff0: coeff_ref[c.caddr][63:0] = mem[c.maddr[16:1]];
			marlann_pkg::op_load_coeff1: coeff_ref[c.caddr][127:64] = mem[c.maddr[16:1]];
			marlann_pkg::op_set_vbp: vbp = c.maddr;
			marlann_pkg::op_add_vbp: vbp = vbp + c.maddr;
			marlann_pkg::op_set_sbp: sbp = c.maddr;
			marlann_pkg::op_add_sbp: sbp = sbp + c.maddr;
			marlann_pkg::op_set_cbp: cbp = c.caddr;
			marlann_pkg::op_add_cbp: cbp = cbp + c.caddr;
			marlann_pkg::op_macc, marlann_pkg::op_maccz: begin
				b = c.maddr + vbp;
				v = mem[b[16:1]];
				e = coeff_ref[9'(c.caddr + cbp)];
				for (int i = 0; i < 16; i++) begin
					if (i < 8)
						s0 += $signed(v[(i%8)*8 +: 8]) * $signed(e[i*8 +: 8]);
					else
						s1 += $signed(v[(i%8)*8 +: 8]) * $signed(e[i*8 +: 8]);
				end
				if (c.opcode == marlann_pkg::op_maccz) begin
					acc0 = 0;
					acc1 = 0;
				end
				acc0 += s0;
				acc1 += s1;
			end
			marlann_pkg::op_ld_set0: acc0 = mem[c.maddr[16:1]][31:0];
			marlann_pkg::op_ld_set1: acc1 = mem[c.maddr[16:1]][63:32];
			marlann_pkg::op_ld_set: {acc1, acc0} = mem[c.maddr[16:1]];
			marlann_pkg::op_store: lanes = 2'b11;
			marlann_pkg::op_store0: lanes = 2'b01;
			marlann_pkg::op_store1: lanes = 2'b10;
			default: ;
		endcase
		if (lanes != 2'b00) begin
			b = c.maddr + sbp;
			exp_addr.push_back(b[16:1]);
			exp_mask.push_back({6'b0, lanes} << b[0]);
			exp_data.push_back({48'b0, clamp_byte(acc1 >>> c.caddr),
				clamp_byte(acc0 >>> c.caddr)} << (8 * b[0]));
			stores++;
		end
		if (c.opcode inside {marlann_pkg::op_macc, marlann_pkg::op_maccz})
			simd_exp++;
		else
			nosimd_exp++;
	endtask

	// holds the command until the DUT takes it.
	task automatic issue(input marlann_pkg::insn_t c);
		cmd_insn = c;
		cmd_valid = 1'b1;
		@(negedge clock);
		while (!cmd_ready) begin
			stalls++;
			@(negedge clock);
		end
		model(c);
		@(posedge clock);
		#2;
	endtask

	task automatic build_program();
		int r;
		prog.push_back(make(marlann_pkg::op_load_coeff0, 20, 3));
		prog.push_back(make(marlann_pkg::op_load_coeff1, 22, 3));
		prog.push_back(make(marlann_pkg::op_load_coeff0, 24, 4));
		prog.push_back(make(marlann_pkg::op_load_coeff1, 26, 4));
		prog.push_back(make(marlann_pkg::op_set_cbp, 0, 3)); // gap after the last load.
		prog.push_back(make(marlann_pkg::op_set_vbp, 40, 0));
		prog.push_back(make(marlann_pkg::op_maccz, 0, 0));
		prog.push_back(make(marlann_pkg::op_macc, 2, 1));
		prog.push_back(make(marlann_pkg::op_set_sbp, 'h10000, 0));
		prog.push_back(make(marlann_pkg::op_store, 0, 0)); // saturates.
		prog.push_back(make(marlann_pkg::op_store, 2, 11)); // fits a byte.
		prog.push_back(make(marlann_pkg::op_ld_set0, 60, 0));
		prog.push_back(make(marlann_pkg::op_store0, 5, 0));
		prog.push_back(make(marlann_pkg::op_ld_set1, 62, 0));
		prog.push_back(make(marlann_pkg::op_add_sbp, 8, 0));
		prog.push_back(make(marlann_pkg::op_store1, 2, 4));
		prog.push_back(make(marlann_pkg::op_ld_set, 64, 0));
		prog.push_back(make(marlann_pkg::op_store0, 10, 16)); // even byte lane.
		prog.push_back(make(marlann_pkg::op_store, 7, 24));
		prog.push_back(make(marlann_pkg::op_store1, 9, 28));
		// mixed burst to provoke slot conflicts.
		for (int k = 0; k < 16; k++) begin
			r = $urandom % 4;
			case (r)
				0: prog.push_back(make(marlann_pkg::op_macc, 2 * ($urandom % 200), $urandom % 2));
				1: prog.push_back(make(marlann_pkg::op_ld_set, 2 * ($urandom % 200), 0));
				2: prog.push_back(make(marlann_pkg::op_store, $urandom % 16, $urandom % 24));
				default: prog.push_back(make(marlann_pkg::op_add_sbp, 16, 0));
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////
	// memory model, 3-cycle reads
	always @(negedge clock) begin
		rd_valid <= {rd_valid[1:0], mem_ren};
		rd_addr[0] <= mem_addr;
		rd_addr[1] <= rd_addr[0];
		rd_addr[2] <= rd_addr[1];
		if (tick_simd)
			simd_seen++;
		if (tick_nosimd)
			nosimd_seen++;
		if (!reset && |mem_wen) begin
			assert (exp_addr.size() != 0)
				else abort("write with no store pending");
			assert (mem_addr == exp_addr[0])
				else mismatch("mem_addr", mem_addr, exp_addr[0]);
			assert (mem_wen == exp_mask[0])
				else mismatch("mem_wen", mem_wen, exp_mask[0]);
			for (int k = 0; k < 8; k++)
				assert (!mem_wen[k] || mem_wdata[k*8 +: 8] == exp_data[0][k*8 +: 8])
					else mismatch("mem_wdata", mem_wdata, exp_data[0]);
			for (int k = 0; k < 8; k++)
				if (mem_wen[k])
					mem[mem_addr][k*8 +: 8] = mem_wdata[k*8 +: 8];
			void'(exp_addr.pop_front());
			void'(exp_mask.pop_front());
			void'(exp_data.pop_front());
			writes++;
		end
	end

	always @(posedge clock) begin
		#2;
		mem_rdata = rd_valid[2] ? mem[rd_addr[2]] : 64'h0;
	end

	no_read_write: assert property (@(negedge clock) disable iff (reset)
		!(mem_ren && |mem_wen))
		else abort("memory port read and write in the same cycle");
	idle_after_reset: assert property (@(negedge clock)
		$fell(reset) |-> (!busy && !mem_ren && mem_wen == 8'h0 && cmd_ready))
		else abort("DUT not idle after reset");
	busy_on_port: assert property (@(negedge clock) disable iff (reset)
		(mem_ren || |mem_wen) |-> busy)
		else abort("memory port used while busy is low");
	simd_tick_read: assert property (@(negedge clock) disable iff (reset)
		tick_simd |-> (mem_ren && !tick_nosimd))
		else abort("tick_simd without its vector read");

	initial begin
		void'($urandom(57));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		mem_rdata = '0;
		rd_valid = '0;
		for (int i = 0; i < 65536; i++)
			mem[i] = {$urandom, $urandom};
		build_program();
		fork
			begin
				#((40 * prog.size() + 200) * 40);
				abort("watchdog timeout");
			end
		join_none
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		@(posedge clock);
		#2;
		foreach (prog[i])
			issue(prog[i]);
		cmd_valid = 1'b0;
		@(negedge clock);
		while (busy)
			@(negedge clock);
		repeat (2) @(negedge clock);
		if (writes == stores && exp_addr.size() == 0 && stalls > 0 &&
				simd_seen == simd_exp && nosimd_seen == nosimd_exp) begin
			$display("test passed");
			$finish;
		end else begin
			$display("writes %0d stores %0d stalls %0d simd %0d/%0d nosimd %0d/%0d",
				writes, stores, stalls, simd_seen, simd_exp, nosimd_seen, nosimd_exp);
			abort("final counts disagree with the reference model");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
logic/marlann_pkg.sv
logic/issue_interlock.sv
logic/coeff_store.sv
logic/mul_array.sv
logic/accumulator_unit.sv
logic/store_unit.sv
logic/marlann_compute.sv
verification/tb_clock.sv
verification/marlann_tb.sv

// ==== Makefile ====
# Verilator build and run of the compute engine testbench.
VERILATOR ?= verilator
TOP       ?= marlann_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
